/* collision_check.sv */
`timescale 1ns/1ns

module collision_check (
	input game_pkg::vec_t player_pos,
	input game_pkg::vec_t player_size,
	input game_pkg::vec_t stage_pos,
	input game_pkg::vec_t stage_size,
	output game_pkg::coll_t coll
);

	// One extra bit so far edges do not wrap
	logic signed [16:0] px0, px1, py0, py1;
	logic signed [16:0] sx0, sx1, sy0, sy1;
	logic signed [16:0] pcx, pcy, scx, scy;

	assign px0 = player_pos.x;
	assign py0 = player_pos.y;
	assign px1 = player_pos.x + player_size.x; // Exclusive edge
	assign py1 = player_pos.y + player_size.y;
	assign sx0 = stage_pos.x;
	assign sy0 = stage_pos.y;
	assign sx1 = stage_pos.x + stage_size.x;
	assign sy1 = stage_pos.y + stage_size.y;

	assign pcx = player_pos.x + (player_size.x >>> 1);
	assign pcy = player_pos.y + (player_size.y >>> 1);
	assign scx = stage_pos.x + (stage_size.x >>> 1);
	assign scy = stage_pos.y + (stage_size.y >>> 1);

	always_comb begin
		coll.overlap = (px0 < sx1) && (sx0 < px1) && (py0 < sy1) && (sy0 < py1);
		coll.left = pcx < scx;
		coll.above = pcy < scy;
		// Far corner may sit exactly on the screen edge
		coll.offscreen = (px0 < 0) || (py0 < 0)
			|| (px1 > game_pkg::SCREEN_W) || (py1 > game_pkg::SCREEN_H);
	end

endmodule

/* data_mem.sv */
`timescale 1ns/1ns

module data_mem #(
	parameter int MEM_ADDR_W = 8
) (
	input logic clock,
	input logic wren,
	input logic [MEM_ADDR_W-1:0] addr,
	input logic [31:0] data,
	output logic [31:0] q
);

	logic [31:0] mem [0:(2**MEM_ADDR_W)-1];

	always_ff @(posedge clock) begin
		if (wren) begin
			mem[addr] <= data;
		end
		q <= mem[addr]; // Old word on a write cycle
	end

endmodule

/* display_packer.sv */
`timescale 1ns/1ns

module display_packer #(
	parameter int NUM_PLAYERS = 2
) (
	input logic clock,
	input logic reset,
	input game_pkg::player_state_t [NUM_PLAYERS-1:0] state,
	input game_pkg::player_ctrl_t [NUM_PLAYERS-1:0] ctrl,
	output game_pkg::display_t [NUM_PLAYERS-1:0] display
);

	logic [NUM_PLAYERS-1:0] facing_q;
	logic [NUM_PLAYERS-1:0] facing_next;

	// Holds last direction when both or neither pressed
	always_comb begin
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			facing_next[p] = facing_q[p];
			if (ctrl[p].buttons[game_pkg::BTN_RIGHT] && !ctrl[p].buttons[game_pkg::BTN_LEFT]) begin
				facing_next[p] = 1'b1;
			end else if (ctrl[p].buttons[game_pkg::BTN_LEFT]
				&& !ctrl[p].buttons[game_pkg::BTN_RIGHT]) begin
				facing_next[p] = 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			facing_q <= '0;
			display <= '0;
		end else begin
			facing_q <= facing_next;
			for (int p = 0; p < NUM_PLAYERS; p++) begin
				display[p].pos <= state[p].pos;
				display[p].size <= ctrl[p].size;
				display[p].buttons <= ctrl[p].buttons;
				display[p].zero <= '0;
				display[p].facing <= facing_next[p]; // Includes this cycle's input
				display[p].coll <= state[p].coll;
			end
		end
	end

endmodule

/* game_mmio.sv */
`timescale 1ns/1ns

module game_mmio #(
	parameter int NUM_PLAYERS = 2,
	parameter int MEM_ADDR_W = 8
) (
	input logic clock,
	input logic reset,
	input logic wren,
	input logic [12:0] address,
	input logic [31:0] data_in,
	output logic [31:0] data_out,
	output logic mem_wren,
	output logic [MEM_ADDR_W-1:0] mem_addr,
	input logic [31:0] mem_q,
	output game_pkg::player_ctrl_t [NUM_PLAYERS-1:0] ctrl,
	output game_pkg::world_t world,
	output logic step,
	output logic spawn,
	input game_pkg::player_state_t [NUM_PLAYERS-1:0] state
);

	logic is_reg;
	logic [4:0] unit_idx;
	logic [4:0] reg_idx;
	logic cmd_wr;
	logic [31:0] reg_rdata;
	logic [31:0] rd_data_q;
	logic rd_mem_q; // Last read went to data memory

	assign is_reg = address[12];
	assign unit_idx = address[11:7];
	assign reg_idx = address[6:2];

	assign mem_wren = wren & ~is_reg;
	assign mem_addr = address[MEM_ADDR_W-1:0];

	assign cmd_wr = wren && is_reg && (unit_idx == game_pkg::UNIT_GLOBAL)
		&& (reg_idx == game_pkg::REG_CMD);

	// Register read select, zero for anything unmapped
	always_comb begin
		reg_rdata = '0;
		if (is_reg) begin
			if (unit_idx == game_pkg::UNIT_GLOBAL) begin
				case (reg_idx)
					game_pkg::REG_GRAVITY: reg_rdata = {16'b0, world.gravity};
					game_pkg::REG_WIND: reg_rdata = {16'b0, world.wind};
					game_pkg::REG_STAGE_POS: reg_rdata = world.stage_pos;
					game_pkg::REG_STAGE_SIZE: reg_rdata = world.stage_size;
					default: reg_rdata = '0; // CMD reads back zero
				endcase
			end
			for (int p = 0; p < NUM_PLAYERS; p++) begin
				if (unit_idx == 5'(p)) begin
					case (reg_idx)
						game_pkg::REG_START: reg_rdata = ctrl[p].start_pos;
						game_pkg::REG_SIZE: reg_rdata = ctrl[p].size;
						game_pkg::REG_CTRL: reg_rdata = ctrl[p].buttons;
						game_pkg::REG_POS: reg_rdata = state[p].pos;
						game_pkg::REG_VEL: reg_rdata = state[p].vel;
						game_pkg::REG_COLL: reg_rdata = {28'b0, state[p].coll};
						default: reg_rdata = '0;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl <= '0;
			world <= '0;
			step <= 1'b0;
			spawn <= 1'b0;
			rd_mem_q <= 1'b0;
			rd_data_q <= '0;
		end else begin
			step <= cmd_wr & data_in[game_pkg::CMD_STEP]; // One cycle only
			spawn <= cmd_wr & data_in[game_pkg::CMD_SPAWN];
			rd_mem_q <= ~is_reg; // Lines up with mem_q
			rd_data_q <= reg_rdata;

			if (wren && is_reg) begin
				if (unit_idx == game_pkg::UNIT_GLOBAL) begin
					case (reg_idx)
						game_pkg::REG_GRAVITY: world.gravity <= data_in[15:0];
						game_pkg::REG_WIND: world.wind <= data_in[15:0];
						game_pkg::REG_STAGE_POS: world.stage_pos <= data_in;
						game_pkg::REG_STAGE_SIZE: world.stage_size <= data_in;
						default: ;
					endcase
				end
				for (int p = 0; p < NUM_PLAYERS; p++) begin
					if (unit_idx == 5'(p)) begin
						case (reg_idx)
							game_pkg::REG_START: ctrl[p].start_pos <= data_in;
							game_pkg::REG_SIZE: ctrl[p].size <= data_in;
							game_pkg::REG_CTRL: ctrl[p].buttons <= data_in;
							default: ; // State registers are read only
						endcase
					end
				end
			end
		end
	end

	// Memory word is already registered inside data_mem
	assign data_out = rd_mem_q ? mem_q : rd_data_q;

endmodule

/* game_pkg.sv */
package game_pkg;

	// One bus word, x in the upper half
	typedef struct packed {
		logic signed [15:0] x;
		logic signed [15:0] y; // Grows downward
	} vec_t;

	typedef struct packed {
		vec_t start_pos;
		vec_t size;
		logic [31:0] buttons; // Controller word from the processor
	} player_ctrl_t;

	typedef struct packed {
		logic signed [15:0] gravity;
		logic signed [15:0] wind;
		vec_t stage_pos;
		vec_t stage_size;
	} world_t;

	typedef struct packed {
		logic offscreen; // Bit 3
		logic above;     // Bit 2, centre y above stage centre
		logic left;      // Bit 1, centre x left of stage centre
		logic overlap;   // Bit 0
	} coll_t;

	typedef struct packed {
		vec_t pos;
		vec_t vel;
		coll_t coll;
	} player_state_t;

	// Display word per player
	typedef struct packed {
		vec_t pos;
		vec_t size;
		logic [31:0] buttons;
		logic [26:0] zero;
		logic facing; // 1 faces right
		coll_t coll;
	} display_t;

	localparam logic signed [15:0] RUN_SPEED = 16'sd3;
	localparam logic signed [15:0] JUMP_SPEED = 16'sd12;
	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;

	// Controller bits
	localparam int BTN_LEFT = 0;
	localparam int BTN_RIGHT = 1;
	localparam int BTN_JUMP = 2;

	// Unit numbers, address bits 11:7
	localparam logic [4:0] UNIT_GLOBAL = 5'd8;

	// Player registers, address bits 6:2
	localparam logic [4:0] REG_START = 5'd0;
	localparam logic [4:0] REG_SIZE = 5'd1;
	localparam logic [4:0] REG_CTRL = 5'd2;
	localparam logic [4:0] REG_POS = 5'd4;
	localparam logic [4:0] REG_VEL = 5'd5;
	localparam logic [4:0] REG_COLL = 5'd6;

	// Global registers
	localparam logic [4:0] REG_GRAVITY = 5'd0;
	localparam logic [4:0] REG_WIND = 5'd1;
	localparam logic [4:0] REG_STAGE_POS = 5'd2;
	localparam logic [4:0] REG_STAGE_SIZE = 5'd3;
	localparam logic [4:0] REG_CMD = 5'd4;

	localparam int CMD_STEP = 0;
	localparam int CMD_SPAWN = 1;

endpackage

/* game_top.sv */
`timescale 1ns/1ns

module game_top #(
	parameter int NUM_PLAYERS = 2, // 1 to 4
	parameter int MEM_ADDR_W = 8
) (
	input logic clock,
	input logic reset,
	input logic wren,
	input logic [12:0] address,
	input logic [31:0] data_in,
	output logic [31:0] data_out,
	output game_pkg::display_t [NUM_PLAYERS-1:0] display
);

	logic mem_wren;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [31:0] mem_q;
	logic step;
	logic spawn;
	game_pkg::player_ctrl_t [NUM_PLAYERS-1:0] ctrl;
	game_pkg::world_t world;
	game_pkg::player_state_t [NUM_PLAYERS-1:0] state;

	game_mmio #(
		.NUM_PLAYERS(NUM_PLAYERS),
		.MEM_ADDR_W(MEM_ADDR_W)
	) mmio_i (
		.clock(clock),
		.reset(reset),
		.wren(wren),
		.address(address),
		.data_in(data_in),
		.data_out(data_out),
		.mem_wren(mem_wren),
		.mem_addr(mem_addr),
		.mem_q(mem_q),
		.ctrl(ctrl),
		.world(world),
		.step(step),
		.spawn(spawn),
		.state(state)
	);

	data_mem #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) mem_i (
		.clock(clock),
		.wren(mem_wren),
		.addr(mem_addr),
		.data(data_in), // Shares the bus write data
		.q(mem_q)
	);

	// One physics lane per player, all on the same strobes
	for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_lane
		player_lane lane_i (
			.clock(clock),
			.reset(reset),
			.step(step),
			.spawn(spawn),
			.ctrl(ctrl[i]),
			.world(world),
			.state(state[i])
		);
	end

	display_packer #(
		.NUM_PLAYERS(NUM_PLAYERS)
	) packer_i (
		.clock(clock),
		.reset(reset),
		.state(state),
		.ctrl(ctrl),
		.display(display)
	);

endmodule

/* player_lane.sv */
`timescale 1ns/1ns

module player_lane (
	input logic clock,
	input logic reset,
	input logic step,
	input logic spawn,
	input game_pkg::player_ctrl_t ctrl,
	input game_pkg::world_t world,
	output game_pkg::player_state_t state
);

	game_pkg::vec_t pos_q;
	game_pkg::vec_t vel_q;
	game_pkg::vec_t pos_next;
	game_pkg::vec_t vel_next;
	game_pkg::coll_t coll;
	logic left, right, jump;
	logic grounded;
	logic landing;

	collision_check coll_i (
		.player_pos(pos_q),
		.player_size(ctrl.size),
		.stage_pos(world.stage_pos),
		.stage_size(world.stage_size),
		.coll(coll)
	);

	assign left = ctrl.buttons[game_pkg::BTN_LEFT];
	assign right = ctrl.buttons[game_pkg::BTN_RIGHT];
	assign jump = ctrl.buttons[game_pkg::BTN_JUMP];

	// Standing on top of the stage
	assign grounded = coll.overlap && coll.above && (vel_q.y >= 0);
	assign landing = coll.overlap && coll.above && (vel_q.y > 0); // Falling into it

	always_comb begin
		vel_next.x = world.wind;
		if (right) begin
			vel_next.x = vel_next.x + game_pkg::RUN_SPEED;
		end
		if (left) begin
			vel_next.x = vel_next.x - game_pkg::RUN_SPEED;
		end
		pos_next.x = pos_q.x + vel_next.x;

		if (grounded && jump) begin
			vel_next.y = -game_pkg::JUMP_SPEED;
			pos_next.y = pos_q.y + vel_next.y;
		end else if (landing) begin
			vel_next.y = '0;
			pos_next.y = world.stage_pos.y - ctrl.size.y; // Feet on stage top
		end else begin
			vel_next.y = vel_q.y + world.gravity;
			pos_next.y = pos_q.y + vel_next.y;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pos_q <= '0;
			vel_q <= '0;
		end else if (spawn) begin // Wins over step
			pos_q <= ctrl.start_pos;
			vel_q <= '0;
		end else if (step) begin
			pos_q <= pos_next;
			vel_q <= vel_next;
		end
	end

	always_comb begin
		state.pos = pos_q;
		state.vel = vel_q;
		state.coll = coll; // Live, follows pos
	end

endmodule

/* sim.f */
game_pkg.sv
data_mem.sv
collision_check.sv
player_lane.sv
display_packer.sv
game_mmio.sv
game_top.sv
tb_game.sv

/* tb_game.sv */
`timescale 1ns/1ns

module tb_game;

	localparam int NP = 2;
	localparam int MAX_CYCLES = 4000;
	localparam logic [12:0] IDLE_ADDR = 13'h1ffc; // Unmapped, reads zero
	localparam logic [12:0] CMD_ADDR = {1'b1, game_pkg::UNIT_GLOBAL, game_pkg::REG_CMD, 2'b00};

	logic clock, reset, wren;
	logic [12:0] address;
	logic [31:0] data_in;
	logic [31:0] data_out;
	game_pkg::display_t [NP-1:0] display;

	// Reference model state
	logic [31:0] mem_m [0:255];
	bit mem_ok [0:255];
	game_pkg::player_ctrl_t ctrl_m [NP];
	game_pkg::world_t world_m;
	game_pkg::vec_t pos_m [NP];
	game_pkg::vec_t vel_m [NP];
	logic step_m, spawn_m;
	logic [NP-1:0] facing_m;
	game_pkg::display_t exp_disp [NP];
	logic [31:0] exp_out;
	bit out_ok = 0;

	logic [31:0] seed = 32'hb30f;
	string test_name = "reset";
	int test_errs = 0, total_errs = 0, tests_ok = 0, tests_bad = 0;

	game_top #(.NUM_PLAYERS(NP), .MEM_ADDR_W(8)) dut_i (
		.clock(clock),
		.reset(reset),
		.wren(wren),
		.address(address),
		.data_in(data_in),
		.data_out(data_out),
		.display(display)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [12:0] reg_addr(input logic [4:0] unit, input logic [4:0] r);
		return {1'b1, unit, r, 2'b00};
	endfunction

	function automatic logic [31:0] vec_of(input int x, input int y);
		return {x[15:0], y[15:0]};
	endfunction

	// Half-open boxes, centres by arithmetic shift
	function automatic game_pkg::coll_t coll_of(input game_pkg::vec_t pos,
		input game_pkg::vec_t size, input game_pkg::world_t w);
		int px, py, pw, ph, sx, sy, sw, sh;
		game_pkg::coll_t c;
		px = pos.x;
		py = pos.y;
		pw = size.x;
		ph = size.y;
		sx = w.stage_pos.x;
		sy = w.stage_pos.y;
		sw = w.stage_size.x;
		sh = w.stage_size.y;
		c.overlap = (px < sx + sw) && (sx < px + pw) && (py < sy + sh) && (sy < py + ph);
		c.left = (px + (pw >>> 1)) < (sx + (sw >>> 1));
		c.above = (py + (ph >>> 1)) < (sy + (sh >>> 1));
		c.offscreen = (px < 0) || (py < 0) || (px + pw > 640) || (py + ph > 480);
		return c;
	endfunction

	function automatic void advance_player(inout game_pkg::vec_t pos, inout game_pkg::vec_t vel,
		input game_pkg::player_ctrl_t c, input game_pkg::world_t w);
		game_pkg::coll_t k;
		k = coll_of(pos, c.size, w); // Collision before the step
		vel.x = w.wind;
		if (c.buttons[1]) vel.x = vel.x + game_pkg::RUN_SPEED;
		if (c.buttons[0]) vel.x = vel.x - game_pkg::RUN_SPEED;
		pos.x = pos.x + vel.x;
		if (k.overlap && k.above && vel.y >= 0 && c.buttons[2]) begin
			vel.y = -game_pkg::JUMP_SPEED;
			pos.y = pos.y + vel.y;
		end else if (k.overlap && k.above && vel.y > 0) begin
			vel.y = '0;
			pos.y = w.stage_pos.y - c.size.y; // Landed on top
		end else begin
			vel.y = vel.y + w.gravity;
			pos.y = pos.y + vel.y;
		end
	endfunction

	function automatic logic [31:0] reg_value(input logic [12:0] a);
		int p;
		p = a[11:7];
		if (a[11:7] == game_pkg::UNIT_GLOBAL) begin
			case (a[6:2])
				game_pkg::REG_GRAVITY: return {16'b0, world_m.gravity};
				game_pkg::REG_WIND: return {16'b0, world_m.wind};
				game_pkg::REG_STAGE_POS: return world_m.stage_pos;
				game_pkg::REG_STAGE_SIZE: return world_m.stage_size;
				default: return '0;
			endcase
		end else if (p < NP) begin
			case (a[6:2])
				game_pkg::REG_START: return ctrl_m[p].start_pos;
				game_pkg::REG_SIZE: return ctrl_m[p].size;
				game_pkg::REG_CTRL: return ctrl_m[p].buttons;
				game_pkg::REG_POS: return pos_m[p];
				game_pkg::REG_VEL: return vel_m[p];
				game_pkg::REG_COLL: return {28'b0, coll_of(pos_m[p], ctrl_m[p].size, world_m)};
				default: return '0;
			endcase
		end
		return '0;
	endfunction

	// Cycle model, all reads use values from before the edge
	always @(posedge clock) begin : ref_model
		int p;
		if (reset) begin
			for (p = 0; p < NP; p++) begin
				ctrl_m[p] = '0;
				pos_m[p] = '0;
				vel_m[p] = '0;
				exp_disp[p] = '0;
			end
			world_m = '0;
			{step_m, spawn_m, facing_m} = '0;
			exp_out = '0;
			out_ok = 1;
		end else begin
			for (p = 0; p < NP; p++) begin
				if (ctrl_m[p].buttons[1] && !ctrl_m[p].buttons[0]) facing_m[p] = 1'b1;
				else if (ctrl_m[p].buttons[0] && !ctrl_m[p].buttons[1]) facing_m[p] = 1'b0;
				exp_disp[p] = '0;
				exp_disp[p].pos = pos_m[p];
				exp_disp[p].size = ctrl_m[p].size;
				exp_disp[p].buttons = ctrl_m[p].buttons;
				exp_disp[p].facing = facing_m[p];
				exp_disp[p].coll = coll_of(pos_m[p], ctrl_m[p].size, world_m);
			end
			exp_out = address[12] ? reg_value(address) : mem_m[address[7:0]];
			out_ok = address[12] ? 1'b1 : mem_ok[address[7:0]]; // Unwritten memory is unknown
			for (p = 0; p < NP; p++) begin
				if (spawn_m) begin
					pos_m[p] = ctrl_m[p].start_pos;
					vel_m[p] = '0;
				end else if (step_m) begin
					advance_player(pos_m[p], vel_m[p], ctrl_m[p], world_m);
				end
			end
			step_m = wren && (address == CMD_ADDR) && data_in[0];
			spawn_m = wren && (address == CMD_ADDR) && data_in[1];
			p = address[11:7];
			if (wren && !address[12]) begin
				mem_m[address[7:0]] = data_in;
				mem_ok[address[7:0]] = 1;
			end else if (wren && address[11:7] == game_pkg::UNIT_GLOBAL) begin
				case (address[6:2])
					game_pkg::REG_GRAVITY: world_m.gravity = data_in[15:0];
					game_pkg::REG_WIND: world_m.wind = data_in[15:0];
					game_pkg::REG_STAGE_POS: world_m.stage_pos = data_in;
					game_pkg::REG_STAGE_SIZE: world_m.stage_size = data_in;
					default: ;
				endcase
			end else if (wren && p < NP) begin
				case (address[6:2])
					game_pkg::REG_START: ctrl_m[p].start_pos = data_in;
					game_pkg::REG_SIZE: ctrl_m[p].size = data_in;
					game_pkg::REG_CTRL: ctrl_m[p].buttons = data_in;
					default: ;
				endcase
			end
		end
	end

	// Outputs only move at rising edges, so compare mid-cycle
	always @(negedge clock) begin
		if (out_ok) begin
			assert (data_out === exp_out) else begin
				$display("CHECK FAILED %s: data_out expected %h actual %h", test_name, exp_out,
					data_out);
				test_errs++;
				total_errs++;
			end
		end
		for (int p = 0; p < NP; p++) begin
			assert (display[p] === exp_disp[p]) else begin
				$display("CHECK FAILED %s: display[%0d] expected %h actual %h", test_name, p,
					exp_disp[p], display[p]);
				test_errs++;
				total_errs++;
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	task automatic bus_write(input logic [12:0] a, input logic [31:0] d);
		@(negedge clock);
		address = a;
		data_in = d;
		wren = 1'b1;
	endtask

	task automatic bus_read(input logic [12:0] a);
		@(negedge clock);
		address = a;
		wren = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) bus_read(IDLE_ADDR);
	endtask

	task automatic start_test(input string name);
		@(posedge clock);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		idle_cycles(3);
		@(posedge clock); // Checker is quiet here
		if (test_errs == 0) begin
			$display("test %s: ok", test_name);
			tests_ok++;
		end else begin
			$display("test %s: %0d failed checks", test_name, test_errs);
			tests_bad++;
		end
	endtask

	task automatic setup_world(input int gravity, input int wind);
		bus_write(reg_addr(game_pkg::UNIT_GLOBAL, game_pkg::REG_GRAVITY), gravity);
		bus_write(reg_addr(game_pkg::UNIT_GLOBAL, game_pkg::REG_WIND), wind);
		bus_write(reg_addr(game_pkg::UNIT_GLOBAL, game_pkg::REG_STAGE_POS), vec_of(200, 300));
		bus_write(reg_addr(game_pkg::UNIT_GLOBAL, game_pkg::REG_STAGE_SIZE), vec_of(240, 20));
	endtask

	task automatic setup_player(input int p, input int x, input int y, input logic [31:0] btn);
		bus_write(reg_addr(p, game_pkg::REG_START), vec_of(x, y));
		bus_write(reg_addr(p, game_pkg::REG_SIZE), vec_of(16, 32));
		bus_write(reg_addr(p, game_pkg::REG_CTRL), btn);
	endtask

	// Pos is read twice to see the old and then the new state
	task automatic step_and_read();
		bus_write(CMD_ADDR, 32'd1);
		for (int p = 0; p < NP; p++) begin
			bus_read(reg_addr(p, game_pkg::REG_POS));
			bus_read(reg_addr(p, game_pkg::REG_POS));
			bus_read(reg_addr(p, game_pkg::REG_VEL));
			bus_read(reg_addr(p, game_pkg::REG_COLL));
		end
	endtask

	initial begin
		logic [12:0] addrs [16];
		int order [16];
		logic [31:0] r;
		logic [31:0] btn_seq [6];
		int j, t;
		reset = 1'b1;
		wren = 1'b0;
		address = IDLE_ADDR;
		data_in = '0;
		repeat (8) @(negedge clock);
		reset = 1'b0;

		start_test("data_memory");
		for (int i = 0; i < 16; i++) begin
			r = lcg_next();
			addrs[i] = {1'b0, r[27:16]}; // Upper bits alias onto the 256 words
			order[i] = i;
			bus_write(addrs[i], lcg_next());
		end
		for (int i = 15; i > 0; i--) begin
			r = lcg_next();
			j = r[23:16] % (i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < 16; i++) bus_read(addrs[order[i]]);
		end_test();

		start_test("registers");
		for (int p = 0; p < NP; p++) begin
			for (int k = 0; k < 3; k++) bus_write(reg_addr(p, k), lcg_next());
		end
		for (int k = 0; k < 4; k++) bus_write(reg_addr(game_pkg::UNIT_GLOBAL, k), lcg_next());
		bus_write(reg_addr(0, game_pkg::REG_POS), lcg_next()); // Read only
		bus_write(reg_addr(3, game_pkg::REG_START), lcg_next());
		bus_write(reg_addr(game_pkg::UNIT_GLOBAL, 7), lcg_next());
		for (int u = 0; u < 4; u++) begin
			for (int k = 0; k < 8; k++) bus_read(reg_addr(u, k));
		end
		for (int k = 0; k < 8; k++) bus_read(reg_addr(game_pkg::UNIT_GLOBAL, k));
		bus_read(reg_addr(9, 0));
		bus_read(reg_addr(31, 2));
		end_test();

		start_test("free_fall");
		setup_world(1, 0);
		setup_player(0, 40, 20, 0);
		setup_player(1, 560, 440, 0); // Drops off the bottom edge
		bus_write(CMD_ADDR, 32'd2);
		repeat (10) step_and_read();
		end_test();

		start_test("horizontal");
		setup_world(0, 32'h0000ffff); // Wind of -1
		setup_player(0, 300, 100, 0);
		setup_player(1, 100, 100, 0);
		bus_write(CMD_ADDR, 32'd3); // Spawn wins over step
		for (int i = 0; i < 4; i++) begin
			bus_write(reg_addr(0, game_pkg::REG_CTRL), (i + 1) % 4);
			bus_write(reg_addr(1, game_pkg::REG_CTRL), 3 - i);
			step_and_read();
		end
		end_test();

		start_test("landing_jump");
		setup_world(2, 0);
		setup_player(0, 240, 250, 0); // Left of stage centre
		setup_player(1, 400, 250, 0);
		bus_write(CMD_ADDR, 32'd2);
		repeat (6) step_and_read();
		bus_write(reg_addr(0, game_pkg::REG_CTRL), 32'd4);
		bus_write(reg_addr(1, game_pkg::REG_CTRL), 32'd4);
		repeat (3) step_and_read();
		end_test();

		start_test("display");
		btn_seq = '{32'd2, 32'd0, 32'd1, 32'd3, 32'd0, 32'd2};
		for (int i = 0; i < 6; i++) begin
			bus_write(reg_addr(0, game_pkg::REG_CTRL), btn_seq[i]);
			bus_write(reg_addr(1, game_pkg::REG_CTRL), btn_seq[5 - i]);
			idle_cycles(1);
			bus_write(CMD_ADDR, 32'd1);
			idle_cycles(3);
		end
		end_test();

		$display("%0d tests ok, %0d tests failed, %0d failed checks", tests_ok, tests_bad,
			total_errs);
		if (total_errs == 0 && tests_bad == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
